// File: cache_config.svh
// Sizes are tied to the 16-bit address split tag 15:10, set 9:4, word 3:1; other values break slicing
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

////////////////////////////////////////
// Bus widths
////////////////////////////////////////
`define CACHE_ADDR_W 16       // Byte address width of both ports
`define CACHE_WORD_W 16       // Data word width, bit 0 of the address is ignored

////////////////////////////////////////
// Address fields
////////////////////////////////////////
`define CACHE_TAG_LSB 10      // Tag runs from here up to the top address bit
`define CACHE_IDX_LSB 4       // Set index runs from here up to the tag
`define CACHE_OFS_LSB 1       // Word offset within a line runs from here up to the index

////////////////////////////////////////
// Organization and timing
////////////////////////////////////////
`define CACHE_SETS 64         // Two ways per set, 2 KB in total
`define CACHE_LINE_WORDS 8    // One line fill is this many memory handshakes

// Cycles the controller waits for mem_ack before it gives up on the access
`define CACHE_MEM_TIMEOUT 1000

`endif

// File: mem_pkg.sv
// Bus types shared by the CPU and memory ports; one word moves per handshake, no byte enables
`include "cache_config.svh"

package mem_pkg;

  typedef logic [`CACHE_ADDR_W-1:0] addr_t;  // Byte address, bit 0 unused
  typedef logic [`CACHE_WORD_W-1:0] word_t;  // One data word

  // Kind of access on either handshake
  typedef enum logic {
    ACC_READ  = 1'b0,
    ACC_WRITE = 1'b1
  } access_t;

endpackage

// File: cache_pkg.sv
// Cache organization types; field widths follow the fixed address split in the config header
`include "cache_config.svh"

package cache_pkg;

  ////////////////////////////////////////
  // Address fields
  ////////////////////////////////////////

  // Tag stored per way and compared on every lookup
  typedef logic [`CACHE_ADDR_W-`CACHE_TAG_LSB-1:0] tag_t;

  // Set number, picks one of the 64 sets
  typedef logic [`CACHE_TAG_LSB-`CACHE_IDX_LSB-1:0] index_t;

  // Word within the line, also the fill counter
  typedef logic [`CACHE_IDX_LSB-`CACHE_OFS_LSB-1:0] offset_t;

  ////////////////////////////////////////
  // Ways and controller state
  ////////////////////////////////////////

  typedef enum logic {
    WAY_0 = 1'b0,  // First way
    WAY_1 = 1'b1   // Second way
  } way_t;

  // The *_REQ states wait for mem_ack low, the *_WAIT states hold mem_req until mem_ack
  typedef enum logic [2:0] {
    IDLE      = 3'd0,  // Waiting for cpu_req
    LOOKUP    = 3'd1,  // Tags compared, hit and victim latched
    FILL_REQ  = 3'd2,  // Memory idle check between fill words
    FILL_WAIT = 3'd3,  // Fill word requested
    WT_REQ    = 3'd4,  // Array write and memory idle check
    WT_WAIT   = 3'd5,  // Write-through word requested
    RESPOND   = 3'd6,  // Result registered, cpu_ack raised
    RELEASE   = 3'd7   // Holding cpu_ack until cpu_req falls
  } ctrl_state_t;

endpackage

// File: cache_array.sv
// Lookup is purely combinational on arr_addr; writes land on the next edge; victim follows LRU only
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_array (
  input  logic             clk,
  input  logic             rst,
  input  mem_pkg::addr_t   arr_addr,        // Address being looked up or written
  input  mem_pkg::word_t   arr_data,        // Word to store on arr_write_data
  input  logic             arr_write_data,  // Store arr_data at arr_addr
  input  logic             arr_write_tag,   // Install the tag of arr_addr in arr_fill_way
  input  logic             arr_touch,       // Mark arr_touch_way as most recent
  input  cache_pkg::way_t  arr_touch_way,
  input  cache_pkg::way_t  arr_fill_way,    // Way chosen for the current line fill
  output logic             hit,
  output cache_pkg::way_t  hit_way,
  output cache_pkg::way_t  victim_way,
  output mem_pkg::word_t   rd_data
);

  import mem_pkg::*;
  import cache_pkg::*;

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////
  tag_t  tag_mem  [2][`CACHE_SETS];                      // One tag per way and set
  word_t data_mem [2][`CACHE_SETS][`CACHE_LINE_WORDS];   // Line data
  logic [1:0][`CACHE_SETS-1:0] valid;                    // Valid bit per way and set
  logic [`CACHE_SETS-1:0]      lru;                      // Holds the least recent way of each set

  // Address fields of the current access
  tag_t    a_tag;
  index_t  a_idx;
  offset_t a_ofs;

  logic match_0;  // Way 0 holds the addressed line
  logic match_1;  // Way 1 holds the addressed line
  way_t wr_way;   // Way that a data write goes to

  assign a_tag = arr_addr[`CACHE_ADDR_W-1:`CACHE_TAG_LSB];
  assign a_idx = arr_addr[`CACHE_TAG_LSB-1:`CACHE_IDX_LSB];
  assign a_ofs = arr_addr[`CACHE_IDX_LSB-1:`CACHE_OFS_LSB];

  ////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////

  // Both ways are compared in parallel
  assign match_0 = valid[0][a_idx] && (tag_mem[0][a_idx] == a_tag);
  assign match_1 = valid[1][a_idx] && (tag_mem[1][a_idx] == a_tag);

  assign hit        = match_0 | match_1;
  assign hit_way    = match_1 ? WAY_1 : WAY_0;  // Both ways never hold the same tag
  assign victim_way = way_t'(lru[a_idx]);       // The least recent way is the one to replace

  // Word of the hitting way or zero on a miss
  always_comb begin
    if (match_1) begin
      rd_data = data_mem[1][a_idx][a_ofs];
    end else if (match_0) begin
      rd_data = data_mem[0][a_idx][a_ofs];
    end else begin
      rd_data = '0;
    end
  end

  // A hit keeps its own way, a miss writes into the way being filled
  assign wr_way = hit ? hit_way : arr_fill_way;

  ////////////////////////////////////////
  // Data words
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (arr_write_data) begin
      data_mem[wr_way][a_idx][a_ofs] <= arr_data;
    end
  end

  ////////////////////////////////////////
  // Tags, valid bits and recency
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;  // Every way starts empty
      lru   <= '0;  // Way 0 is replaced first
    end else begin
      // Fill words land in a way whose old contents are being overwritten,
      // so that way stays invalid until its new tag goes in
      if (arr_write_data && !hit) begin
        valid[arr_fill_way][a_idx] <= 1'b0;
      end
      if (arr_write_tag) begin
        valid[arr_fill_way][a_idx] <= 1'b1;  // Later assignment wins over the clear above
      end
      if (arr_touch) begin
        lru[a_idx] <= ~arr_touch_way;  // The other way becomes the victim
      end
    end
  end

  // The tag store is written once per line fill
  always_ff @(posedge clk) begin
    if (arr_write_tag) begin
      tag_mem[arr_fill_way][a_idx] <= a_tag;
    end
  end

endmodule

// File: cache_ctrl.sv
// One CPU request in flight; a memory timeout abandons the fill or write-through and answers miss, 0
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_ctrl (
  input  logic              clk,
  input  logic              rst,
  // CPU side
  input  logic              cpu_req,
  input  mem_pkg::access_t  cpu_kind,
  input  mem_pkg::addr_t    cpu_addr,
  input  mem_pkg::word_t    cpu_wdata,
  output logic              cpu_ack,
  output mem_pkg::word_t    cpu_rdata,
  output logic              cpu_hit,
  // Memory side
  output logic              mem_req,
  output mem_pkg::access_t  mem_kind,
  output mem_pkg::addr_t    mem_addr,
  output mem_pkg::word_t    mem_wdata,
  input  logic              mem_ack,
  input  mem_pkg::word_t    mem_rdata,
  // Array side
  output mem_pkg::addr_t    arr_addr,
  output mem_pkg::word_t    arr_data,
  output logic              arr_write_data,
  output logic              arr_write_tag,
  output logic              arr_touch,
  output cache_pkg::way_t   arr_touch_way,
  output cache_pkg::way_t   arr_fill_way,
  input  logic              hit,
  input  cache_pkg::way_t   hit_way,
  input  cache_pkg::way_t   victim_way,
  input  mem_pkg::word_t    rd_data
);

  import mem_pkg::*;
  import cache_pkg::*;

  localparam int unsigned WD_W = $clog2(`CACHE_MEM_TIMEOUT + 1);  // Watchdog counter width

  ctrl_state_t     state;
  access_t         req_kind;     // Request latched when it is accepted
  addr_t           req_addr;
  word_t           req_wdata;
  logic            hit_flag;     // Line was present at lookup
  way_t            fill_way;     // Victim latched at lookup
  offset_t         fill_cnt;     // Next word of the line to fetch
  logic            phase_done;   // Last memory handshake of the phase was acknowledged
  logic            abort;        // Memory timed out on this request
  logic [WD_W-1:0] wd_cnt;       // Cycles spent waiting for mem_ack
  logic            wd_expired;
  logic            in_fill;
  addr_t           fill_addr;

  assign in_fill    = (state == FILL_REQ) || (state == FILL_WAIT);
  assign fill_addr  = {req_addr[`CACHE_ADDR_W-1:`CACHE_IDX_LSB], fill_cnt, {`CACHE_OFS_LSB{1'b0}}};
  assign wd_expired = (wd_cnt == WD_W'(`CACHE_MEM_TIMEOUT - 1));

  ////////////////////////////////////////
  // Memory and array drive
  ////////////////////////////////////////
  assign mem_req   = (state == FILL_WAIT) || (state == WT_WAIT);  // High only while waiting for ack
  assign mem_kind  = ((state == WT_REQ) || (state == WT_WAIT)) ? ACC_WRITE : ACC_READ;
  assign mem_addr  = in_fill ? fill_addr : req_addr;
  assign mem_wdata = req_wdata;

  assign arr_addr = in_fill ? fill_addr : req_addr;
  assign arr_data = in_fill ? mem_rdata : req_wdata;  // Fill words come from memory

  // Each fill word is stored as it is acknowledged; the CPU word goes in once before write-through
  assign arr_write_data = ((state == FILL_WAIT) && mem_ack) ||
                          ((state == WT_REQ) && !mem_ack && !phase_done);
  assign arr_write_tag  = (state == FILL_WAIT) && mem_ack && (fill_cnt == '1);  // Line complete

  assign arr_touch     = (state == RESPOND) && hit;  // No touch when a fill was abandoned
  assign arr_touch_way = hit_way;
  assign arr_fill_way  = fill_way;

  ////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst || !mem_req) begin
      wd_cnt <= '0;  // Every wait state is entered with a fresh count
    end else begin
      wd_cnt <= wd_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////
  // State machine
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= IDLE;
      cpu_ack    <= 1'b0;
      hit_flag   <= 1'b0;
      fill_cnt   <= '0;
      phase_done <= 1'b0;
      abort      <= 1'b0;
    end else begin
      case (state)
        IDLE: if (cpu_req) begin
          state      <= LOOKUP;
          fill_cnt   <= '0;
          phase_done <= 1'b0;
          abort      <= 1'b0;
        end
        LOOKUP: begin
          hit_flag <= hit;
          if (!hit) state <= FILL_REQ;
          else      state <= (req_kind == ACC_WRITE) ? WT_REQ : RESPOND;
        end
        FILL_REQ: if (!mem_ack) begin  // Memory back to idle
          if (!phase_done) begin
            state <= FILL_WAIT;
          end else begin
            phase_done <= 1'b0;  // Write-through starts its own phase
            state      <= (req_kind == ACC_WRITE) ? WT_REQ : RESPOND;
          end
        end
        FILL_WAIT: if (mem_ack) begin
          fill_cnt   <= fill_cnt + 1'b1;
          phase_done <= (fill_cnt == '1);
          state      <= FILL_REQ;
        end else if (wd_expired) begin
          abort <= 1'b1;  // Give up on the line, write-through is skipped too
          state <= RESPOND;
        end
        WT_REQ: if (!mem_ack) begin
          state <= phase_done ? RESPOND : WT_WAIT;
        end
        WT_WAIT: if (mem_ack) begin
          phase_done <= 1'b1;
          state      <= WT_REQ;
        end else if (wd_expired) begin
          abort <= 1'b1;
          state <= RESPOND;
        end
        RESPOND: begin
          cpu_ack <= 1'b1;  // Result registers load on this same edge
          state   <= RELEASE;
        end
        RELEASE: if (!cpu_req) begin
          cpu_ack <= 1'b0;
          state   <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Request and result payload
  always_ff @(posedge clk) begin
    if (state == IDLE && cpu_req) begin
      req_kind  <= cpu_kind;
      req_addr  <= cpu_addr;
      req_wdata <= cpu_wdata;
    end
    if (state == LOOKUP) fill_way <= victim_way;
    if (state == RESPOND) begin
      cpu_hit   <= hit_flag && !abort;
      if (abort)                      cpu_rdata <= '0;
      else if (req_kind == ACC_WRITE) cpu_rdata <= req_wdata;  // Echo of the word written
      else                            cpu_rdata <= rd_data;
    end
  end

endmodule

// File: cache_top.sv
// Cache top level; both ports are four-phase req/ack, one word per handshake, one request at a time
`timescale 1ns/1ps

module cache_top (
  input  logic              clk,
  input  logic              rst,
  // CPU port
  input  logic              cpu_req,
  input  mem_pkg::access_t  cpu_kind,
  input  mem_pkg::addr_t    cpu_addr,
  input  mem_pkg::word_t    cpu_wdata,
  output logic              cpu_ack,
  output mem_pkg::word_t    cpu_rdata,
  output logic              cpu_hit,
  // Memory port
  output logic              mem_req,
  output mem_pkg::access_t  mem_kind,
  output mem_pkg::addr_t    mem_addr,
  output mem_pkg::word_t    mem_wdata,
  input  logic              mem_ack,
  input  mem_pkg::word_t    mem_rdata
);

  import mem_pkg::*;
  import cache_pkg::*;

  // Controller to array
  addr_t arr_addr;
  word_t arr_data;
  logic  arr_write_data;
  logic  arr_write_tag;
  logic  arr_touch;
  way_t  arr_touch_way;
  way_t  arr_fill_way;

  // Array lookup results, valid in the same cycle as arr_addr
  logic  hit;
  way_t  hit_way;
  way_t  victim_way;
  word_t rd_data;

  cache_ctrl i_cache_ctrl (
    .clk, .rst,
    .cpu_req, .cpu_kind, .cpu_addr, .cpu_wdata, .cpu_ack, .cpu_rdata, .cpu_hit,
    .mem_req, .mem_kind, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata,
    .arr_addr, .arr_data, .arr_write_data, .arr_write_tag,
    .arr_touch, .arr_touch_way, .arr_fill_way,
    .hit, .hit_way, .victim_way, .rd_data
  );

  cache_array i_cache_array (
    .clk, .rst,
    .arr_addr, .arr_data, .arr_write_data, .arr_write_tag,
    .arr_touch, .arr_touch_way, .arr_fill_way,
    .hit, .hit_way, .victim_way, .rd_data
  );

endmodule

// File: cache_tb_mem.sv
// Word-addressed model of the whole 64 KB space; ack comes 1 to 4 cycles after req, no timeouts
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_tb_mem (
  input  logic             clk,
  input  logic             rst,
  input  logic             mem_req,
  input  mem_pkg::access_t mem_kind,
  input  mem_pkg::addr_t   mem_addr,
  input  mem_pkg::word_t   mem_wdata,
  output logic             mem_ack,
  output mem_pkg::word_t   mem_rdata
);

  import mem_pkg::*;

  localparam int unsigned WORDS = 1 << (`CACHE_ADDR_W - `CACHE_OFS_LSB);

  word_t       mem [WORDS];  // The testbench reads this array directly
  logic [31:0] rng;          // Xorshift state, first the fill and then the delays
  logic        armed;        // A delay has been drawn for the current request
  logic [1:0]  delay;        // Cycles still to wait before ack

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Each word mixes the random stream with its own address
  initial begin
    rng = 32'd28772;
    for (int i = 0; i < WORDS; i++) begin
      rng    = xorshift32(rng);
      mem[i] = rng[15:0] ^ word_t'(i);
    end
    mem_ack   = 1'b0;
    mem_rdata = '0;
    armed     = 1'b0;
    delay     = '0;
  end

  ////////////////////////////////////////
  // Four-phase responder
  ////////////////////////////////////////
  always @(posedge clk) begin
    if (rst) begin
      mem_ack <= 1'b0;
      armed   <= 1'b0;
    end else if (mem_ack) begin
      if (!mem_req) mem_ack <= 1'b0;  // Return to zero once the request is gone
    end else if (mem_req) begin
      if (!armed) begin
        rng   <= xorshift32(rng);
        delay <= rng[1:0];            // Extra wait of 0 to 3 cycles
        armed <= 1'b1;
      end else if (delay != 0) begin
        delay <= delay - 1'b1;
      end else begin
        armed   <= 1'b0;
        mem_ack <= 1'b1;              // Read data is valid with ack
        if (mem_kind == ACC_WRITE) begin
          mem[mem_addr[`CACHE_ADDR_W-1:`CACHE_OFS_LSB]] <= mem_wdata;
        end else begin
          mem_rdata <= mem[mem_addr[`CACHE_ADDR_W-1:`CACHE_OFS_LSB]];
        end
      end
    end
  end

endmodule

// File: cache_tb.sv
// Directed tests of cache_top against a shadow model; outputs are sampled on the falling edge
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_tb;

  import mem_pkg::*;

  localparam int unsigned N_TESTS   = 6;
  localparam int unsigned MIX_OPS   = 200;
  localparam int unsigned ACC_CYC   = 200;                      // Bound for one access with fill
  localparam int unsigned ACK_LIMIT = 10 * `CACHE_MEM_TIMEOUT;  // Covers a fully timed out fill
  localparam int unsigned WORDS     = 1 << (`CACHE_ADDR_W - `CACHE_OFS_LSB);
  localparam longint      WATCHDOG_NS = longint'(N_TESTS * 40 + MIX_OPS) * ACC_CYC * 20;

  logic    clk;
  logic    rst;
  logic    cpu_req;
  access_t cpu_kind;
  addr_t   cpu_addr;
  word_t   cpu_wdata;
  logic    cpu_ack;
  word_t   cpu_rdata;
  logic    cpu_hit;
  logic    mem_req;
  access_t mem_kind;
  addr_t   mem_addr;
  word_t   mem_wdata;
  logic    mem_ack;
  word_t   mem_rdata;

  // Shadow of memory and of the tag state of every set
  word_t       shadow_mem [WORDS];
  logic [5:0]  shadow_tag [`CACHE_SETS][2];
  logic        shadow_valid [`CACHE_SETS][2];
  logic        shadow_lru [`CACHE_SETS];  // Least recent way and so the next victim
  logic [31:0] rng;
  int unsigned word_errs, flag_errs, lat_errs, proto_errs;

  cache_top i_cache_top (.*);

  cache_tb_mem i_mem (
    .clk, .rst, .mem_req, .mem_kind, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests completed");
    report_counts();
    $display("Regression failed");
    $finish;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic addr_t make_addr(input int unsigned tag, input int unsigned set,
                                      input int unsigned ofs);
    return addr_t'((tag << `CACHE_TAG_LSB) | (set << `CACHE_IDX_LSB) | (ofs << `CACHE_OFS_LSB));
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      word_errs++;
      $display("FAIL at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_hit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      flag_errs++;
      $display("FAIL at %0t ns: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      lat_errs++;
      $display("FAIL at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  task automatic report_counts();
    $display("Errors: cpu_rdata %0d, flags %0d, latency %0d, handshake %0d",
             word_errs, flag_errs, lat_errs, proto_errs);
  endtask

  task automatic init_shadow();
    for (int i = 0; i < WORDS; i++) shadow_mem[i] = i_mem.mem[i];  // Initial memory image
    for (int s = 0; s < `CACHE_SETS; s++) begin
      shadow_valid[s][0] = 1'b0;
      shadow_valid[s][1] = 1'b0;
      shadow_lru[s]      = 1'b0;
    end
  endtask

  // Applies one access to the shadow and returns the expected hit and word
  task automatic predict_access(input access_t kind, input addr_t addr, input word_t wdata,
                                output logic exp_hit, output word_t exp_data);
    int unsigned set;
    int unsigned widx;
    logic [5:0]  tag;
    logic        way;
    set  = addr[`CACHE_TAG_LSB-1:`CACHE_IDX_LSB];
    widx = addr[`CACHE_ADDR_W-1:`CACHE_OFS_LSB];
    tag  = addr[`CACHE_ADDR_W-1:`CACHE_TAG_LSB];
    exp_hit = 1'b0;
    way     = shadow_lru[set];  // Replaced unless a way matches
    for (int w = 0; w < 2; w++) begin
      if (shadow_valid[set][w] && shadow_tag[set][w] == tag) begin
        exp_hit = 1'b1;
        way     = w[0];
      end
    end
    if (!exp_hit) begin
      shadow_tag[set][way]   = tag;   // Line fill into the victim
      shadow_valid[set][way] = 1'b1;
    end
    if (kind == ACC_WRITE) shadow_mem[widx] = wdata;  // Write-through keeps memory current
    exp_data        = shadow_mem[widx];
    shadow_lru[set] = ~way;
  endtask

  // One four-phase CPU transaction; latency counts from the edge that first samples cpu_req
  task automatic cpu_access(input access_t kind, input addr_t addr, input word_t wdata,
                            output word_t rdata, output logic hit, output int latency);
    int n;
    n = 0;
    @(posedge clk);
    cpu_req   <= 1'b1;
    cpu_kind  <= kind;
    cpu_addr  <= addr;
    cpu_wdata <= wdata;
    do begin
      @(negedge clk);
      n++;
    end while (!cpu_ack && n < ACK_LIMIT);
    if (!cpu_ack) begin
      proto_errs++;
      $display("cpu_ack never rose for the access to address %h", addr);
    end
    rdata   = cpu_rdata;
    hit     = cpu_hit;
    latency = n - 2;  // Ack rose at edge n-1 and cpu_req was first sampled at edge 1
    @(posedge clk);
    cpu_req <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (cpu_ack && n < ACK_LIMIT);
    if (cpu_ack) begin
      proto_errs++;
      $display("cpu_ack stayed high after cpu_req fell at address %h", addr);
    end
  endtask

  task automatic run_access(input access_t kind, input addr_t addr, input word_t wdata,
                            output logic hit, output int latency);
    logic  exp_hit;
    word_t exp_data;
    word_t got_data;
    predict_access(kind, addr, wdata, exp_hit, exp_data);
    cpu_access(kind, addr, wdata, got_data, hit, latency);
    check_hit($sformatf("cpu_hit @%h", addr), exp_hit, hit);
    check_word($sformatf("cpu_rdata @%h", addr), exp_data, got_data);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////
  task automatic test_reset_read_miss();
    logic h;
    int   lat;
    @(negedge clk);
    check_hit("cpu_ack", 1'b0, cpu_ack);  // Quiet ports right after reset
    check_hit("mem_req", 1'b0, mem_req);
    run_access(ACC_READ, make_addr(5, 1, 2), '0, h, lat);
    check_hit("cpu_hit", 1'b0, h);
    run_access(ACC_READ, make_addr(5, 1, 5), '0, h, lat);  // Same line is now present
    check_hit("cpu_hit", 1'b1, h);
  endtask

  task automatic test_hit_latency();
    logic h;
    int   lat;
    run_access(ACC_READ, make_addr(5, 1, 7), '0, h, lat);
    check_latency("cpu_ack latency", 2, lat);
    run_access(ACC_READ, make_addr(9, 2, 0), '0, h, lat);  // Miss brings in a new line
    run_access(ACC_READ, make_addr(9, 2, 3), '0, h, lat);
    check_hit("cpu_hit", 1'b1, h);
    check_latency("cpu_ack latency", 2, lat);
  endtask

  task automatic test_write_through();
    addr_t a;
    word_t d;
    logic  h;
    int    lat;
    a = make_addr(9, 2, 3);
    d = word_t'(next_rand());
    run_access(ACC_WRITE, a, d, h, lat);
    check_hit("cpu_hit", 1'b1, h);
    run_access(ACC_READ, a, '0, h, lat);
    check_hit("cpu_hit", 1'b1, h);
    check_word("memory word", d, i_mem.mem[a[`CACHE_ADDR_W-1:`CACHE_OFS_LSB]]);
  endtask

  task automatic test_write_allocate();
    addr_t a;
    word_t d;
    logic  h;
    int    lat;
    a = make_addr(17, 3, 4);
    d = word_t'(next_rand());
    run_access(ACC_WRITE, a, d, h, lat);
    check_hit("cpu_hit", 1'b0, h);
    run_access(ACC_READ, make_addr(17, 3, 6), '0, h, lat);  // Neighbour came in with the fill
    check_hit("cpu_hit", 1'b1, h);
    check_word("memory word", d, i_mem.mem[a[`CACHE_ADDR_W-1:`CACHE_OFS_LSB]]);
  endtask

  task automatic test_lru_replacement();
    logic h;
    int   lat;
    run_access(ACC_READ, make_addr(33, 4, 0), '0, h, lat);  // Tag A
    run_access(ACC_READ, make_addr(34, 4, 1), '0, h, lat);  // Tag B
    run_access(ACC_READ, make_addr(33, 4, 2), '0, h, lat);  // A again so B is now least recent
    run_access(ACC_READ, make_addr(35, 4, 3), '0, h, lat);  // Tag C takes the way of B
    run_access(ACC_READ, make_addr(33, 4, 4), '0, h, lat);
    check_hit("cpu_hit", 1'b1, h);
    run_access(ACC_READ, make_addr(34, 4, 5), '0, h, lat);
    check_hit("cpu_hit", 1'b0, h);
  endtask

  task automatic test_random_mix();
    logic [31:0] r;
    access_t     kind;
    logic        h;
    int          lat;
    for (int i = 0; i < MIX_OPS; i++) begin
      r    = next_rand();
      kind = r[0] ? ACC_WRITE : ACC_READ;
      // Four tags over two sets keep both hits and evictions frequent
      run_access(kind, make_addr(48 + r[3:2], 8 + r[4], r[7:5]), r[31:16], h, lat);
    end
  endtask

  ////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////
  initial begin
    rst       = 1'b1;
    cpu_req   = 1'b0;
    cpu_kind  = ACC_READ;
    cpu_addr  = '0;
    cpu_wdata = '0;
    rng       = 32'd28772;
    word_errs = 0;
    flag_errs = 0;
    lat_errs  = 0;
    proto_errs = 0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    init_shadow();
    test_reset_read_miss();
    test_hit_latency();
    test_write_through();
    test_write_allocate();
    test_lru_replacement();
    test_random_mix();
    report_counts();
    if (word_errs + flag_errs + lat_errs + proto_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: cache_top.f
+incdir+.
mem_pkg.sv
cache_pkg.sv
cache_array.sv
cache_ctrl.sv
cache_top.sv
cache_tb_mem.sv
cache_tb.sv

// File: Bender.yml
package:
  name: cache

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - mem_pkg.sv
      - cache_pkg.sv
      - cache_array.sv
      - cache_ctrl.sv
      - cache_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - cache_tb_mem.sv
      - cache_tb.sv
